// ==== hw/decode_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "hub_defs.svh"

module decode_sequencer (
    input  logic clk,
    input  logic reset,

    input  logic start_i,
    input  hub_ctrl_pkg::run_cfg_t cfg_i,

    output hub_msg_pkg::msg_t cmd_data_o,
    output logic cmd_valid_o,
    input  logic cmd_ready_i,

    input  hub_msg_pkg::msg_t res_data_i,
    input  logic res_valid_i,
    output logic res_ready_o,

    output hub_msg_pkg::msg_t result_o,
    output logic result_valid_o,
    output logic busy_o,
    output logic done_o,
    output hub_ctrl_pkg::seq_state_e state_o
);

    localparam int CNT_BITS = $clog2(`HUB_NUM_LEAVES + 1);

    hub_ctrl_pkg::seq_state_e state;
    hub_ctrl_pkg::run_cfg_t cfg_q;
    logic [15:0] round_cnt;
    logic [15:0] round_next;
    logic stage;
    logic [CNT_BITS-1:0] res_cnt;
    logic [CNT_BITS-1:0] res_target;
    hub_msg_pkg::hdr_view_t hdr;
    logic res_take;
    logic last_res;

    // one merged result per round in multi-leaf mode
    assign res_target = cfg_q.multi_leaf_run ? CNT_BITS'(1) : CNT_BITS'(`HUB_NUM_LEAVES);
    assign res_ready_o = (state == hub_ctrl_pkg::WAIT);
    assign res_take = res_ready_o && res_valid_i;
    assign last_res = (res_cnt == res_target - 1'b1);
    assign round_next = round_cnt + 16'd1;

    always_comb begin
        hdr = '0;
        hdr.dest = hub_msg_pkg::BROADCAST_DEST;
        if (state == hub_ctrl_pkg::START) begin
            hdr.msg_type = hub_msg_pkg::START_DECODING;
            hdr.flags[hub_msg_pkg::FLAG_FUSION] = cfg_q.fusion_on;
            hdr.flags[hub_msg_pkg::FLAG_MULTI_LEAF] = cfg_q.multi_leaf_run;
        end else begin
            // stage 0 is bottom, 1 is top
            hdr.msg_type = hub_msg_pkg::MEASUREMENT_HEADER;
            hdr.flags[hub_msg_pkg::FLAG_STAGE] = stage;
        end
    end

    assign cmd_data_o.hdr = hdr;
    assign cmd_valid_o = (state == hub_ctrl_pkg::START) || (state == hub_ctrl_pkg::MEAS);
    assign busy_o = (state != hub_ctrl_pkg::IDLE);
    assign state_o = state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= hub_ctrl_pkg::IDLE;
            cfg_q <= '0;
            round_cnt <= '0;
            stage <= 1'b0;
            res_cnt <= '0;
            done_o <= 1'b0;
            result_valid_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            result_valid_o <= res_take;
            case (state)
                hub_ctrl_pkg::IDLE: begin
                    if (start_i) begin
                        cfg_q <= cfg_i;
                        round_cnt <= '0;
                        if (cfg_i.rounds == '0) begin
                            done_o <= 1'b1;
                        end else begin
                            state <= hub_ctrl_pkg::START;
                        end
                    end
                end
                hub_ctrl_pkg::START: begin
                    if (cmd_ready_i) begin
                        state <= hub_ctrl_pkg::MEAS;
                        stage <= 1'b0;
                    end
                end
                hub_ctrl_pkg::MEAS: begin
                    if (cmd_ready_i) begin
                        if (cfg_q.fusion_on && !stage) begin
                            stage <= 1'b1;
                        end else begin
                            state <= hub_ctrl_pkg::WAIT;
                            res_cnt <= '0;
                        end
                    end
                end
                hub_ctrl_pkg::WAIT: begin
                    if (res_take) begin
                        if (last_res) begin
                            round_cnt <= round_next;
                            if (round_next == cfg_q.rounds) begin
                                done_o <= 1'b1;
                                state <= hub_ctrl_pkg::IDLE;
                            end else begin
                                state <= hub_ctrl_pkg::START;
                            end
                        end else begin
                            res_cnt <= res_cnt + 1'b1;
                        end
                    end
                end
                default: state <= hub_ctrl_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (res_take) begin
            result_o <= res_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/hub_ctrl_pkg.sv ====
`default_nettype none

package hub_ctrl_pkg;

    // captured by the sequencer on start_i
    typedef struct packed {
        logic fusion_on;
        logic multi_leaf_run;
        logic [15:0] rounds;
    } run_cfg_t;

    typedef enum logic [1:0] {
        IDLE,
        START,
        MEAS,
        WAIT
    } seq_state_e;

endpackage

`default_nettype wire

// ==== hw/hub_defs.svh ====
`ifndef HUB_DEFS_SVH
`define HUB_DEFS_SVH

// leaf decoder links on the hub, up to 8
`define HUB_NUM_LEAVES 4

// depth of every message FIFO in words
`define HUB_FIFO_DEPTH 16

// pipeline stages modelling one router hop
`define HUB_ROUTER_DELAY 3

// message word width
`define HUB_WORD_BITS 64

`endif

// ==== hw/hub_msg_pkg.sv ====
`default_nettype none

`include "hub_defs.svh"

package hub_msg_pkg;

    localparam logic [7:0] BROADCAST_DEST = 8'hff;

    // bit positions inside the header flags byte
    localparam int FLAG_MULTI_LEAF = 0;
    localparam int FLAG_FUSION = 1;
    localparam int FLAG_STAGE = 0;

    typedef enum logic [7:0] {
        START_DECODING = 8'h01,
        MEASUREMENT_HEADER = 8'h02,
        RESULT = 8'h03
    } msg_type_e;

    // downlink view, sequencer to leaves
    typedef struct packed {
        logic [7:0] dest;
        msg_type_e msg_type;
        logic [`HUB_WORD_BITS-25:0] reserved;
        logic [7:0] flags;
    } hdr_view_t;

    // uplink view, leaf result report
    typedef struct packed {
        logic [7:0] dest;
        msg_type_e msg_type;
        logic [7:0] iterations;
        logic [15:0] cycles;
        logic [7:0] leaf_id;
        logic [15:0] tag;
    } res_view_t;

    typedef union packed {
        hdr_view_t hdr;
        res_view_t res;
    } msg_t;

endpackage

`default_nettype wire

// ==== hw/hub_router.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "hub_defs.svh"

module hub_router (
    input  logic clk,
    input  logic reset,

    // broadcast input from the controller
    input  hub_msg_pkg::msg_t ctl_data_i,
    input  logic ctl_valid_i,
    output logic ctl_ready_o,

    output hub_msg_pkg::msg_t [`HUB_NUM_LEAVES-1:0] leaf_down_data_o,
    output logic [`HUB_NUM_LEAVES-1:0] leaf_down_valid_o,
    input  logic [`HUB_NUM_LEAVES-1:0] leaf_down_ready_i,

    input  hub_msg_pkg::msg_t [`HUB_NUM_LEAVES-1:0] leaf_up_data_i,
    input  logic [`HUB_NUM_LEAVES-1:0] leaf_up_valid_i,
    output logic [`HUB_NUM_LEAVES-1:0] leaf_up_ready_o,

    // merged results back to the controller
    output hub_msg_pkg::msg_t ctl_up_data_o,
    output logic ctl_up_valid_o,
    input  logic ctl_up_ready_i
);

    localparam int N = `HUB_NUM_LEAVES;
    localparam int LEAF_BITS = (N > 1) ? $clog2(N) : 1;

    logic [N-1:0] sent;
    logic [N-1:0] taken;
    logic [LEAF_BITS-1:0] rr_ptr;
    logic [LEAF_BITS-1:0] sel;
    logic found;

    // leaves that already took the current word are masked off
    always_comb begin
        for (int i = 0; i < N; i++) begin
            leaf_down_data_o[i] = ctl_data_i;
        end
    end

    assign leaf_down_valid_o = {N{ctl_valid_i}} & ~sent;
    assign taken = sent | (leaf_down_valid_o & leaf_down_ready_i);
    assign ctl_ready_o = &taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            sent <= '0;
        end else if (ctl_valid_i) begin
            sent <= ctl_ready_o ? '0 : taken;
        end
    end

    // first valid leaf at or after the round-robin pointer
    always_comb begin
        int idx;
        found = 1'b0;
        sel = rr_ptr;
        for (int off = 0; off < N; off++) begin
            idx = (int'(rr_ptr) + off) % N;
            if (!found && leaf_up_valid_i[idx]) begin
                found = 1'b1;
                sel = LEAF_BITS'(idx);
            end
        end
    end

    assign ctl_up_valid_o = found;
    assign ctl_up_data_o = leaf_up_data_i[sel];

    always_comb begin
        for (int i = 0; i < N; i++) begin
            leaf_up_ready_o[i] = found && ctl_up_ready_i && (sel == LEAF_BITS'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= '0;
        end else if (found && ctl_up_ready_i) begin
            rr_ptr <= (sel == LEAF_BITS'(N - 1)) ? '0 : sel + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/link_delay_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "hub_defs.svh"

module link_delay_fifo #(
    parameter int DEPTH = `HUB_FIFO_DEPTH,
    parameter int DELAY = `HUB_ROUTER_DELAY
) (
    input  logic clk,
    input  logic reset,

    input  hub_msg_pkg::msg_t in_data_i,
    input  logic in_valid_i,
    output logic in_ready_o,

    output hub_msg_pkg::msg_t out_data_o,
    output logic out_valid_o,
    input  logic out_ready_i
);

    hub_msg_pkg::msg_t fifo_data;
    logic fifo_valid;
    hub_msg_pkg::msg_t stage_data [DELAY];
    logic [DELAY-1:0] stage_valid;
    hub_msg_pkg::msg_t src_data [DELAY];
    logic [DELAY-1:0] src_valid;
    logic [DELAY-1:0] advance;

    msg_fifo #(
        .DEPTH(DEPTH)
    ) u_fifo (
        .clk(clk),
        .reset(reset),
        .in_data_i(in_data_i),
        .in_valid_i(in_valid_i),
        .in_ready_o(in_ready_o),
        .out_data_o(fifo_data),
        .out_valid_o(fifo_valid),
        .out_ready_i(advance[0])
    );

    // a stage moves when it is empty or the next one moves
    always_comb begin
        advance[DELAY-1] = !stage_valid[DELAY-1] || out_ready_i;
        for (int k = DELAY - 2; k >= 0; k--) begin
            advance[k] = !stage_valid[k] || advance[k+1];
        end
        src_data[0] = fifo_data;
        src_valid[0] = fifo_valid;
        for (int k = 1; k < DELAY; k++) begin
            src_data[k] = stage_data[k-1];
            src_valid[k] = stage_valid[k-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else begin
            for (int k = 0; k < DELAY; k++) begin
                if (advance[k]) begin
                    stage_valid[k] <= src_valid[k];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < DELAY; k++) begin
            if (advance[k]) begin
                stage_data[k] <= src_data[k];
            end
        end
    end

    assign out_data_o = stage_data[DELAY-1];
    assign out_valid_o = stage_valid[DELAY-1];

endmodule

`default_nettype wire

// ==== hw/msg_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "hub_defs.svh"

module msg_fifo #(
    parameter int DEPTH = `HUB_FIFO_DEPTH
) (
    input  logic clk,
    input  logic reset,

    input  hub_msg_pkg::msg_t in_data_i,
    input  logic in_valid_i,
    output logic in_ready_o,

    output hub_msg_pkg::msg_t out_data_o,
    output logic out_valid_o,
    input  logic out_ready_i
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    hub_msg_pkg::msg_t mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic push;
    logic pop;

    assign in_ready_o = (count != CNT_BITS'(DEPTH));
    assign out_valid_o = (count != '0);
    assign push = in_valid_i && in_ready_o;
    assign pop = out_valid_o && out_ready_i;

    // head word is read straight from storage
    assign out_data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/root_hub_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "hub_defs.svh"

module root_hub_top (
    input  logic clk,
    input  logic reset,

    input  logic start_i,
    input  hub_ctrl_pkg::run_cfg_t cfg_i,

    output hub_msg_pkg::msg_t [`HUB_NUM_LEAVES-1:0] down_data_o,
    output logic [`HUB_NUM_LEAVES-1:0] down_valid_o,
    input  logic [`HUB_NUM_LEAVES-1:0] down_ready_i,

    input  hub_msg_pkg::msg_t [`HUB_NUM_LEAVES-1:0] up_data_i,
    input  logic [`HUB_NUM_LEAVES-1:0] up_valid_i,
    output logic [`HUB_NUM_LEAVES-1:0] up_ready_o,

    output hub_msg_pkg::msg_t result_o,
    output logic result_valid_o,
    output logic busy_o,
    output logic done_o,
    output hub_ctrl_pkg::seq_state_e state_o
);

    hub_msg_pkg::msg_t cmd_data;
    logic cmd_valid;
    logic cmd_ready;
    hub_msg_pkg::msg_t ctl_data;
    logic ctl_valid;
    logic ctl_ready;
    hub_msg_pkg::msg_t ret_data;
    logic ret_valid;
    logic ret_ready;
    hub_msg_pkg::msg_t res_data;
    logic res_valid;
    logic res_ready;
    hub_msg_pkg::msg_t [`HUB_NUM_LEAVES-1:0] leaf_down_data;
    logic [`HUB_NUM_LEAVES-1:0] leaf_down_valid;
    logic [`HUB_NUM_LEAVES-1:0] leaf_down_ready;
    hub_msg_pkg::msg_t [`HUB_NUM_LEAVES-1:0] leaf_up_data;
    logic [`HUB_NUM_LEAVES-1:0] leaf_up_valid;
    logic [`HUB_NUM_LEAVES-1:0] leaf_up_ready;

    decode_sequencer u_seq (
        .clk(clk), .reset(reset),
        .start_i(start_i), .cfg_i(cfg_i),
        .cmd_data_o(cmd_data), .cmd_valid_o(cmd_valid), .cmd_ready_i(cmd_ready),
        .res_data_i(res_data), .res_valid_i(res_valid), .res_ready_o(res_ready),
        .result_o(result_o), .result_valid_o(result_valid_o),
        .busy_o(busy_o), .done_o(done_o), .state_o(state_o)
    );

    // local paths between the sequencer and the router
    msg_fifo #(.DEPTH(`HUB_FIFO_DEPTH)) u_cmd_fifo (
        .clk(clk), .reset(reset),
        .in_data_i(cmd_data), .in_valid_i(cmd_valid), .in_ready_o(cmd_ready),
        .out_data_o(ctl_data), .out_valid_o(ctl_valid), .out_ready_i(ctl_ready)
    );

    msg_fifo #(.DEPTH(`HUB_FIFO_DEPTH)) u_res_fifo (
        .clk(clk), .reset(reset),
        .in_data_i(ret_data), .in_valid_i(ret_valid), .in_ready_o(ret_ready),
        .out_data_o(res_data), .out_valid_o(res_valid), .out_ready_i(res_ready)
    );

    hub_router u_router (
        .clk(clk), .reset(reset),
        .ctl_data_i(ctl_data), .ctl_valid_i(ctl_valid), .ctl_ready_o(ctl_ready),
        .leaf_down_data_o(leaf_down_data), .leaf_down_valid_o(leaf_down_valid),
        .leaf_down_ready_i(leaf_down_ready),
        .leaf_up_data_i(leaf_up_data), .leaf_up_valid_i(leaf_up_valid),
        .leaf_up_ready_o(leaf_up_ready),
        .ctl_up_data_o(ret_data), .ctl_up_valid_o(ret_valid), .ctl_up_ready_i(ret_ready)
    );

    for (genvar i = 0; i < `HUB_NUM_LEAVES; i++) begin : g_leaf
        link_delay_fifo #(.DEPTH(`HUB_FIFO_DEPTH), .DELAY(`HUB_ROUTER_DELAY)) u_down (
            .clk(clk), .reset(reset),
            .in_data_i(leaf_down_data[i]), .in_valid_i(leaf_down_valid[i]),
            .in_ready_o(leaf_down_ready[i]),
            .out_data_o(down_data_o[i]), .out_valid_o(down_valid_o[i]),
            .out_ready_i(down_ready_i[i])
        );

        link_delay_fifo #(.DEPTH(`HUB_FIFO_DEPTH), .DELAY(`HUB_ROUTER_DELAY)) u_up (
            .clk(clk), .reset(reset),
            .in_data_i(up_data_i[i]), .in_valid_i(up_valid_i[i]), .in_ready_o(up_ready_o[i]),
            .out_data_o(leaf_up_data[i]), .out_valid_o(leaf_up_valid[i]),
            .out_ready_i(leaf_up_ready[i])
        );
    end

endmodule

`default_nettype wire

// ==== root_hub_top.f ====
+incdir+hw
hw/hub_msg_pkg.sv
hw/hub_ctrl_pkg.sv
hw/msg_fifo.sv
hw/link_delay_fifo.sv
hw/hub_router.sv
hw/decode_sequencer.sv
hw/root_hub_top.sv
tests/root_hub_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the root hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps --top-module root_hub_tb \
    -Mdir obj_dir -f root_hub_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vroot_hub_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx '\*\* PASS \*\*'; then
    exit 0
fi
echo "pass message not found"
exit 1

// ==== tests/hub_stim.txt ====
# fusion_on multi_leaf_run rounds stall iterations cycles (hex)
# leaf k reports iterations plus k and cycles plus the round index
0 0 0003 0 05 0100
1 0 0002 0 07 0200
0 1 0004 0 03 0040
1 1 0002 0 0a 0300
0 0 0005 1 02 0010
1 0 0003 1 0c 0800
0 1 0003 1 04 0120
1 1 0002 1 09 0a00
1 0 0001 0 01 0001
0 0 0002 1 0f fff0

// ==== tests/root_hub_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "hub_defs.svh"

module root_hub_tb;

    localparam int N = `HUB_NUM_LEAVES;

    logic clk;
    logic reset;
    logic start_i;
    hub_ctrl_pkg::run_cfg_t cfg_i;
    hub_msg_pkg::msg_t [N-1:0] down_data_o;
    logic [N-1:0] down_valid_o;
    logic [N-1:0] down_ready_i;
    hub_msg_pkg::msg_t [N-1:0] up_data_i;
    logic [N-1:0] up_valid_i;
    logic [N-1:0] up_ready_o;
    hub_msg_pkg::msg_t result_o;
    logic result_valid_o;
    logic busy_o;
    logic done_o;
    hub_ctrl_pkg::seq_state_e state_o;

    // tests read from the stimulus file
    hub_ctrl_pkg::run_cfg_t test_cfg[$];
    logic test_stall[$];
    logic [7:0] test_iter[$];
    logic [15:0] test_cyc[$];

    hub_ctrl_pkg::run_cfg_t cur_cfg;
    logic cur_stall;
    logic [7:0] cur_iter;
    logic [15:0] cur_cyc;
    int cur_test;
    int hdrs_per_round;
    logic run_active;
    logic [15:0] done_count;
    logic [15:0] results_seen;
    hub_msg_pkg::msg_t exp_pool[$];

    // leaf model state
    int leaf_pos[N];
    logic [15:0] leaf_round[N];
    logic up_pending[N];
    int up_delay[N];
    hub_msg_pkg::msg_t up_word[N];

    logic [31:0] lfsr_state;
    int cycle_cnt;
    int timeout_limit;

    root_hub_top DUT (
        .clk(clk), .reset(reset),
        .start_i(start_i), .cfg_i(cfg_i),
        .down_data_o(down_data_o), .down_valid_o(down_valid_o), .down_ready_i(down_ready_i),
        .up_data_i(up_data_i), .up_valid_i(up_valid_i), .up_ready_o(up_ready_o),
        .result_o(result_o), .result_valid_o(result_valid_o),
        .busy_o(busy_o), .done_o(done_o), .state_o(state_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic end_in_failure(string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            end_in_failure($sformatf("run timed out after %0d cycles", cycle_cnt));
        end
    end

    // taps 32 22 2 1
    function automatic logic random_bit();
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        return lfsr_state[0];
    endfunction

    task automatic check_msg(string name, hub_msg_pkg::msg_t exp, hub_msg_pkg::msg_t act);
        if (act !== exp) begin
            end_in_failure($sformatf("error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_cfg_flags(string name, logic [7:0] exp, logic [7:0] act);
        if (act !== exp) begin
            end_in_failure($sformatf("error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(string name, logic [15:0] exp, logic [15:0] act);
        if (act !== exp) begin
            end_in_failure($sformatf("error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_state(string name, hub_ctrl_pkg::seq_state_e exp,
                               hub_ctrl_pkg::seq_state_e act);
        if (act !== exp) begin
            end_in_failure($sformatf("error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    // pos 0 is the start word, 1 and 2 the bottom and top measurement headers
    function automatic hub_msg_pkg::msg_t header_word(int pos);
        hub_msg_pkg::msg_t w;
        w = '0;
        w.hdr.dest = 8'hff;
        if (pos == 0) begin
            w.hdr.msg_type = hub_msg_pkg::START_DECODING;
            w.hdr.flags = {6'b0, cur_cfg.fusion_on, cur_cfg.multi_leaf_run};
        end else begin
            w.hdr.msg_type = hub_msg_pkg::MEASUREMENT_HEADER;
            w.hdr.flags = (pos == 2) ? 8'h01 : 8'h00;
        end
        return w;
    endfunction

    function automatic hub_msg_pkg::msg_t result_word(int leaf, logic [15:0] round);
        hub_msg_pkg::msg_t w;
        w = '0;
        w.res.msg_type = hub_msg_pkg::RESULT;
        w.res.iterations = cur_iter + 8'(leaf);
        w.res.cycles = cur_cyc + round;
        w.res.leaf_id = 8'(leaf);
        w.res.tag = {8'(cur_test), round[7:0]};
        return w;
    endfunction

    task automatic take_header(int leaf);
        hub_msg_pkg::msg_t exp;
        logic [3:0] wait_cycles;
        string name;
        name = $sformatf("down_data_o[%0d]", leaf);
        if (leaf_round[leaf] >= cur_cfg.rounds) begin
            end_in_failure($sformatf("leaf %0d received a header after its last round", leaf));
        end
        exp = header_word(leaf_pos[leaf]);
        if (leaf_pos[leaf] == 0) begin
            check_cfg_flags({name, ".flags"}, exp.hdr.flags, down_data_o[leaf].hdr.flags);
        end
        check_msg(name, exp, down_data_o[leaf]);
        leaf_pos[leaf]++;
        if (leaf_pos[leaf] == hdrs_per_round) begin
            leaf_pos[leaf] = 0;
            // only leaf 0 reports in multi-leaf mode
            if (!cur_cfg.multi_leaf_run || leaf == 0) begin
                wait_cycles = '0;
                for (int b = 0; b < 4; b++) begin
                    wait_cycles = {wait_cycles[2:0], random_bit()};
                end
                up_word[leaf] = result_word(leaf, leaf_round[leaf]);
                up_delay[leaf] = int'(wait_cycles);
                up_pending[leaf] = 1'b1;
                exp_pool.push_back(up_word[leaf]);
            end
            leaf_round[leaf]++;
        end
    endtask

    task automatic drive_uplink(int leaf);
        if (up_pending[leaf] && up_delay[leaf] == 0) begin
            up_data_i[leaf] = up_word[leaf];
            up_valid_i[leaf] = 1'b1;
            // taken at the next rising edge
            if (up_ready_o[leaf]) begin
                up_pending[leaf] = 1'b0;
            end
        end else begin
            up_valid_i[leaf] = 1'b0;
            if (up_pending[leaf]) begin
                up_delay[leaf]--;
            end
        end
    endtask

    task automatic match_result(hub_msg_pkg::msg_t act);
        int hit;
        hit = -1;
        foreach (exp_pool[k]) begin
            if (hit < 0 && exp_pool[k].res.leaf_id == act.res.leaf_id) begin
                hit = k;
            end
        end
        if (hit < 0) begin
            end_in_failure($sformatf("result_o carried a word that leaf %0d never sent",
                                     act.res.leaf_id));
        end else begin
            check_msg("result_o", exp_pool[hit], act);
            exp_pool.delete(hit);
            results_seen++;
        end
    endtask

    // one falling edge of the leaf models
    task automatic service_links();
        @(negedge clk);
        if (result_valid_o) begin
            match_result(result_o);
        end
        if (done_o) begin
            done_count++;
            run_active = 1'b0;
        end
        if (!run_active) begin
            check_state("state_o", hub_ctrl_pkg::IDLE, state_o);
            if (busy_o) begin
                end_in_failure("busy_o was high while no run was active");
            end
        end
        for (int i = 0; i < N; i++) begin
            // a multi-leaf run may end before the other leaves drained their headers
            if (!run_active && down_valid_o[i]
                    && (done_count == 0 || leaf_round[i] >= cur_cfg.rounds)) begin
                end_in_failure("a downlink word appeared while no run was started");
            end
            down_ready_i[i] = cur_stall ? random_bit() : 1'b1;
            if (down_valid_o[i] && down_ready_i[i]) begin
                take_header(i);
            end
            drive_uplink(i);
        end
    endtask

    initial begin
        int fd;
        int n;
        int fus;
        int mul;
        int rnd;
        int stl;
        int itr;
        int cyc;
        int total_rounds;
        string line;
        hub_ctrl_pkg::run_cfg_t cfg;
        reset = 1'b1;
        start_i = 1'b0;
        cfg_i = '0;
        down_ready_i = '0;
        up_data_i = '0;
        up_valid_i = '0;
        lfsr_state = 32'he3092f0a;
        cycle_cnt = 0;
        timeout_limit = 0;
        cur_cfg = '0;
        cur_stall = 1'b0;
        run_active = 1'b0;
        total_rounds = 0;
        fd = $fopen("tests/hub_stim.txt", "r");
        if (fd == 0) begin
            end_in_failure("could not open tests/hub_stim.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // comment lines do not scan as hex
            if (n > 0 &&
                    $sscanf(line, "%h %h %h %h %h %h", fus, mul, rnd, stl, itr, cyc) == 6) begin
                cfg.fusion_on = fus[0];
                cfg.multi_leaf_run = mul[0];
                cfg.rounds = 16'(rnd);
                test_cfg.push_back(cfg);
                test_stall.push_back(stl[0]);
                test_iter.push_back(8'(itr));
                test_cyc.push_back(16'(cyc));
                total_rounds += rnd;
            end
        end
        $fclose(fd);
        if (test_cfg.size() == 0) begin
            end_in_failure("the stimulus file holds no test lines");
        end
        // 400 cycles per round plus reset and idle gaps
        timeout_limit = 400 * total_rounds + 64 + 32 * test_cfg.size();

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (down_valid_o != '0 || result_valid_o || done_o || busy_o || up_ready_o != '1) begin
            end_in_failure("outputs were not idle after reset");
        end

        for (int t = 0; t < test_cfg.size(); t++) begin
            cur_test = t;
            cur_cfg = test_cfg[t];
            cur_stall = test_stall[t];
            cur_iter = test_iter[t];
            cur_cyc = test_cyc[t];
            hdrs_per_round = cur_cfg.fusion_on ? 3 : 2;
            done_count = '0;
            results_seen = '0;
            exp_pool.delete();
            for (int i = 0; i < N; i++) begin
                leaf_pos[i] = 0;
                leaf_round[i] = '0;
                up_pending[i] = 1'b0;
                up_delay[i] = 0;
            end
            service_links();
            cfg_i = cur_cfg;
            start_i = 1'b1;
            run_active = 1'b1;
            service_links();
            start_i = 1'b0;
            // start_i was sampled one edge ago
            if (cur_cfg.rounds != '0) begin
                check_state("state_o", hub_ctrl_pkg::START, state_o);
            end
            while (done_count == 0) begin
                service_links();
            end
            // idle window catches stray downlink words and extra done pulses
            repeat (24) service_links();
            check_count("done_o pulses", 16'd1, done_count);
            check_count("result_o words",
                        cur_cfg.rounds * (cur_cfg.multi_leaf_run ? 16'd1 : 16'(N)),
                        results_seen);
            for (int i = 0; i < N; i++) begin
                check_count($sformatf("rounds seen by leaf %0d", i), cur_cfg.rounds,
                            leaf_round[i]);
            end
            check_count("results never delivered", 16'd0, 16'(exp_pool.size()));
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
